//--- project.f
+incdir+hw
hw/loader_pkg.sv
hw/download_router.sv
hw/cart_scanner.sv
hw/bios_packer.sv
hw/cheat_assembler.sv
hw/rom_writer.sv
hw/loader_top.sv
sim/loader_sva.sv
sim/loader_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= loader_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/loader_tb.sv
// Testbench for the download loader, table of downloads against a credit-returning memory model
`timescale 1ns/1ps
`include "loader_macros.svh"

module loader_tb;

	localparam int NUM_DL = 5;
	localparam int MAX_DELAY = 6; // Longest credit return in cycles
	localparam logic [71:0] SIG = "FLASH1M_V"; // First byte on top

	typedef struct {
		logic [7:0] index;
		int nbeats;
		int seed; // Data pattern
		int sig_pos; // Byte offset of the signature, -1 for none
		logic exp_flash;
	} dl_entry_t;

	logic clk_sys;
	logic reset;
	logic dl_active;
	logic dl_wr;
	logic mem_credit = 1'b0;
	logic [`LDR_IDX_W-1:0] dl_index;
	loader_pkg::dl_beat_s dl_beat;
	logic dl_wait;
	logic mem_wr_valid;
	logic bios_wr_valid;
	logic cheat_valid;
	logic cheat_clear;
	loader_pkg::mem_wr_s mem_wr;
	loader_pkg::bios_wr_s bios_wr;
	loader_pkg::cheat_code_t cheat_code;
	loader_pkg::cart_info_s cart_info;
	loader_pkg::cart_info_s exp_info; // Status of the latest cart

	dl_entry_t downloads [NUM_DL];
	loader_pkg::mem_wr_s exp_mem [$];
	loader_pkg::bios_wr_s exp_bios [$];
	loader_pkg::cheat_code_t exp_cheat [$];
	int due_q [$]; // Cycle on which each credit goes back
	int cycle = 0;
	int limit;
	int due;
	int last_due = 0;
	int outstanding = 0; // Writes seen, credits not yet returned
	int clear_count = 0;
	int exp_clears = 0;
	logic [7:0] idx;
	logic [31:0] rng = 32'd14188;

	loader_top u_loader_top (.*);

	bind rom_writer loader_sva u_sva (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns period
	end

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Byte i of the image of download n
	function automatic logic [7:0] image_byte(input int n, input int i);
		int off;
		off = i - downloads[n].sig_pos;
		if (downloads[n].sig_pos >= 0 && off >= 0 && off < 9)
			return SIG[71 - 8*off -: 8];
		return 8'(i * 37 + downloads[n].seed * 11); // Step too wide to spell the signature
	endfunction

	function automatic loader_pkg::dl_data_t half_word(input int n, input int k);
		return {image_byte(n, 2*k + 1), image_byte(n, 2*k)}; // Low byte first in the image
	endfunction

	// Flags, address, compare, replace, each low half-word first
	function automatic loader_pkg::cheat_code_t cheat_entry(input int n, input int k0);
		return {half_word(n, k0 + 1), half_word(n, k0), half_word(n, k0 + 3), half_word(n, k0 + 2),
			half_word(n, k0 + 5), half_word(n, k0 + 4), half_word(n, k0 + 7), half_word(n, k0 + 6)};
	endfunction

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_mem_wr(input loader_pkg::mem_wr_s got, input loader_pkg::mem_wr_s exp);
		if (got !== exp) begin
			$display("** Error: mem_wr got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic check_bios_wr(input loader_pkg::bios_wr_s got, input loader_pkg::bios_wr_s exp);
		if (got !== exp) begin
			$display("** Error: bios_wr got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic check_cheat(input loader_pkg::cheat_code_t got,
		input loader_pkg::cheat_code_t exp);
		if (got !== exp) begin
			$display("** Error: cheat_code got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic check_cart_info(input loader_pkg::cart_info_s got,
		input loader_pkg::cart_info_s exp);
		if (got !== exp) begin
			$display("** Error: cart_info got %h expected %h", got, exp);
			fail_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// ==================================================
	// Memory model and watchdog
	// ==================================================
	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle > limit) begin
			$display("Timeout after %0d cycles, the downloads did not complete", cycle);
			fail_run();
		end
		if (reset) begin
			mem_credit <= 1'b0;
		end else begin
			if (mem_wr_valid) begin
				if (exp_mem.size() == 0) begin
					$display("Memory write seen with no cart beat left to match it");
					fail_run();
				end
				check_mem_wr(mem_wr, exp_mem.pop_front());
				rng = xorshift32(rng);
				due = cycle + 1 + int'(rng % MAX_DELAY);
				last_due = (due > last_due) ? due : last_due + 1; // Credits return in order
				due_q.push_back(last_due);
				outstanding++;
			end
			if (due_q.size() != 0 && due_q[0] <= cycle) begin
				void'(due_q.pop_front());
				mem_credit <= 1'b1; // One credit per cycle at most
				outstanding--;
			end else begin
				mem_credit <= 1'b0;
			end
			if (outstanding > `LDR_ROM_CREDITS) begin
				$display("More memory writes in flight than credits granted");
				fail_run();
			end
		end
	end

	// BIOS and cheat outputs
	always @(posedge clk_sys) begin
		if (!reset) begin
			if (bios_wr_valid) begin
				if (exp_bios.size() == 0) begin
					$display("BIOS write seen with no word expected");
					fail_run();
				end
				check_bios_wr(bios_wr, exp_bios.pop_front());
			end
			if (cheat_clear)
				clear_count++;
			if (cheat_valid) begin
				if (exp_cheat.size() == 0 || clear_count != exp_clears) begin
					$display("Cheat code seen unexpectedly or before its clear pulse");
					fail_run();
				end
				check_cheat(cheat_code, exp_cheat.pop_front());
			end
		end
	end

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		reset <= 1'b1;
		dl_active <= 1'b0;
		dl_index <= '0;
		dl_wr <= 1'b0;
		dl_beat <= '0;
		exp_info = '0;
		downloads[0] = '{8'h41, 40, 3, 0, 1'b1}; // Signature from the first byte
		downloads[1] = '{8'h00, 32, 5, -1, 1'b0}; // BIOS
		downloads[2] = '{8'hC3, 24, 9, -1, 1'b0};
		downloads[3] = '{8'hFF, 24, 17, -1, 1'b0}; // Three cheat entries
		downloads[4] = '{8'h82, 36, 21, 33, 1'b1}; // Odd alignment
		limit = 100 + NUM_DL * 16;
		foreach (downloads[n])
			limit += downloads[n].nbeats * (MAX_DELAY + 2);
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		check_flag("mem_wr_valid", mem_wr_valid, 1'b0);
		check_flag("bios_wr_valid", bios_wr_valid, 1'b0);
		check_flag("cheat_valid", cheat_valid, 1'b0);
		check_flag("cheat_clear", cheat_clear, 1'b0);
		check_flag("dl_wait", dl_wait, 1'b0);
		check_flag("cart_info.loaded", cart_info.loaded, 1'b0);

		foreach (downloads[n]) begin
			idx = downloads[n].index;
			// Expected results straight from the image
			for (int k = 0; k < downloads[n].nbeats; k++) begin
				if (idx == 8'd0 && k % 2 == 1)
					exp_bios.push_back({loader_pkg::bios_addr_t'(k / 2),
						half_word(n, k), half_word(n, k - 1)});
				else if (idx == 8'd255 && k % 8 == 7)
					exp_cheat.push_back(cheat_entry(n, k - 7));
				else if (idx != 8'd0 && idx != 8'd255)
					exp_mem.push_back({loader_pkg::mem_addr_t'(`LDR_ROM_BASE / 2 + k),
						half_word(n, k)});
			end
			if (idx == 8'd255)
				exp_clears++;
			else if (idx != 8'd0)
				exp_info = {1'b1, idx[7:6], downloads[n].exp_flash,
					loader_pkg::dl_addr_t'(2 * (downloads[n].nbeats - 1))};

			dl_active <= 1'b1;
			dl_index <= idx;
			@(posedge clk_sys); // Kind register settles, no strobe yet
			for (int k = 0; k < downloads[n].nbeats; k++) begin
				dl_wr <= 1'b1;
				dl_beat <= {loader_pkg::dl_addr_t'(2 * k), half_word(n, k)};
				@(posedge clk_sys);
				while (dl_wait)
					@(posedge clk_sys); // Beat held until accepted
			end
			dl_wr <= 1'b0;
			dl_active <= 1'b0;
			while (exp_mem.size() != 0 || exp_bios.size() != 0 || exp_cheat.size() != 0)
				@(posedge clk_sys);
			repeat (4) @(posedge clk_sys); // End pulse reaches the status record
			check_cart_info(cart_info, exp_info);
			if (clear_count != exp_clears) begin
				$display("Cheat clear pulsed %0d times, expected %0d", clear_count, exp_clears);
				fail_run();
			end
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- sim/loader_sva.sv
// Assertion checker bound to the ROM writer for credit accounting and host handshake rules
`timescale 1ns/1ps
`include "loader_macros.svh"

module loader_sva (
	input logic clk_sys,
	input logic reset,
	input logic cart_wr,
	input logic dl_wait,
	input logic mem_credit,
	input logic [$clog2(`LDR_ROM_CREDITS + 1)-1:0] credits,
	input loader_pkg::dl_beat_s dl_beat
);

	// ==================================================
	// Credit counter
	// ==================================================
	a_wait_empty: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wait |-> credits == '0) else $error("dl_wait raised with credits left");

	a_credit_max: assert property (@(posedge clk_sys) disable iff (reset)
		credits <= `LDR_ROM_CREDITS) else $error("credit counter above its reset value");

	// Memory hands back only credits it holds
	a_credit_return: assert property (@(posedge clk_sys) disable iff (reset)
		mem_credit |-> credits != `LDR_ROM_CREDITS)
		else $error("credit returned with no write in flight");

	// Stalled host keeps its beat
	a_hold_beat: assert property (@(posedge clk_sys) disable iff (reset)
		cart_wr && dl_wait |=> cart_wr && $stable(dl_beat)) else $error("beat dropped under wait");

endmodule

//--- hw/loader_top.sv
// Download loader top level connecting the router to the scanner, packer, cheat and ROM paths
`timescale 1ns/1ps
`include "loader_macros.svh"

module loader_top (
	input logic clk_sys,
	input logic reset,
	// Host download port
	input logic dl_active,
	input logic [`LDR_IDX_W-1:0] dl_index,
	input logic dl_wr,
	input loader_pkg::dl_beat_s dl_beat,
	output logic dl_wait,
	// External memory
	input logic mem_credit,
	output logic mem_wr_valid,
	output loader_pkg::mem_wr_s mem_wr,
	// BIOS RAM
	output logic bios_wr_valid,
	output loader_pkg::bios_wr_s bios_wr,
	// Cheat engine
	output loader_pkg::cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_clear,
	// Cart status for the core
	output loader_pkg::cart_info_s cart_info
);

	logic cart_start;
	logic cart_end;
	logic cheat_start;
	loader_pkg::cart_type_t cart_type;
	logic cart_wr; // Gated strobes, one per consumer
	logic bios_wr_in;
	logic cheat_wr_in;

	// ==================================================
	// ROM detect
	// ==================================================
	download_router u_router (
		.clk_sys(clk_sys),
		.reset(reset),
		.dl_active(dl_active),
		.dl_index(dl_index),
		.dl_wr(dl_wr),
		.cart_start(cart_start),
		.cart_end(cart_end),
		.cheat_start(cheat_start),
		.cart_type(cart_type),
		.cart_wr(cart_wr),
		.bios_wr_in(bios_wr_in),
		.cheat_wr_in(cheat_wr_in)
	);

	cart_scanner u_scanner (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_start(cart_start),
		.cart_end(cart_end),
		.cart_type(cart_type),
		.cart_wr(cart_wr),
		.dl_beat(dl_beat),
		.cart_info(cart_info)
	);

	// BIOS write
	bios_packer u_bios (
		.clk_sys(clk_sys),
		.reset(reset),
		.bios_wr_in(bios_wr_in),
		.dl_beat(dl_beat),
		.bios_wr_valid(bios_wr_valid),
		.bios_wr(bios_wr)
	);

	// Cart to memory, flow control back to the host
	rom_writer u_rom_writer (
		.clk_sys(clk_sys),
		.reset(reset),
		.cart_wr(cart_wr),
		.cart_start(cart_start),
		.cart_end(cart_end),
		.dl_beat(dl_beat),
		.mem_credit(mem_credit),
		.mem_wr_valid(mem_wr_valid),
		.mem_wr(mem_wr),
		.dl_wait(dl_wait)
	);

	// Codes
	cheat_assembler u_cheat (
		.clk_sys(clk_sys),
		.reset(reset),
		.cheat_start(cheat_start),
		.cheat_wr_in(cheat_wr_in),
		.dl_beat(dl_beat),
		.cheat_code(cheat_code),
		.cheat_valid(cheat_valid),
		.cheat_clear(cheat_clear)
	);

endmodule

//--- hw/rom_writer.sv
// ROM writer that offsets cartridge beats into memory writes under credit-based flow control
`timescale 1ns/1ps
`include "loader_macros.svh"

module rom_writer (
	input logic clk_sys,
	input logic reset,
	input logic cart_wr,
	input logic cart_start,
	input logic cart_end,
	input loader_pkg::dl_beat_s dl_beat,
	input logic mem_credit,
	output logic mem_wr_valid,
	output loader_pkg::mem_wr_s mem_wr,
	output logic dl_wait
);

	localparam int CREDIT_W = $clog2(`LDR_ROM_CREDITS + 1);
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`LDR_ROM_CREDITS);
	// Cart ROM base in half-words
	localparam loader_pkg::mem_addr_t ROM_BASE_HW = loader_pkg::mem_addr_t'(`LDR_ROM_BASE / 2);

	logic [CREDIT_W-1:0] credits; // Writes the memory can still take
	logic cart_active_q; // Inside a cart download, after its first cycle
	logic cart_active; // Same as the router's kind being cart
	logic accept; // Beat taken from the host this cycle

	// ==================================================
	// Cart window
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || cart_end)
			cart_active_q <= 1'b0;
		else if (cart_start)
			cart_active_q <= 1'b1;
	end

	assign cart_active = (cart_start || cart_active_q) && !cart_end;
	assign dl_wait = cart_active && (credits == '0); // Host holds its beat
	assign accept = cart_wr && !dl_wait;

	// ==================================================
	// Credit counter
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({accept, mem_credit})
				2'b10: credits <= credits - 1'b1; // New write in flight
				2'b01: if (credits != CREDIT_MAX) credits <= credits + 1'b1; // Write done
				default: credits <= credits; // Both or neither cancel out
			endcase
		end
	end

	// ==================================================
	// Write request
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			mem_wr.addr <= ROM_BASE_HW + dl_beat.addr[`LDR_ADDR_W-1:1];
			mem_wr.data <= dl_beat.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			mem_wr_valid <= 1'b0;
		else
			mem_wr_valid <= accept; // Exactly one cycle after the beat
	end

endmodule

//--- hw/cheat_assembler.sv
// Cheat assembler that builds 128-bit cheat codes from half-words and pulses clear per download
`timescale 1ns/1ps

module cheat_assembler (
	input logic clk_sys,
	input logic reset,
	input logic cheat_start,
	input logic cheat_wr_in,
	input loader_pkg::dl_beat_s dl_beat,
	output loader_pkg::cheat_code_t cheat_code,
	output logic cheat_valid,
	output logic cheat_clear
);

	// Layout of one entry, 16 bytes in the table
	//   127:96 flags    offsets 0, 2
	//    95:64 address  offsets 4, 6
	//    63:32 compare  offsets 8, 10
	//    31:0  replace  offsets 12, 14
	// Each field arrives low half-word first

	logic [6:0] slot_lsb; // Bit position of the half-word in the code
	logic last_slot; // Offset 14 closes the entry

	// Field index runs backwards, half select picks the upper 16 bits
	assign slot_lsb = {~dl_beat.addr[3:2], dl_beat.addr[1], 4'b0000};
	assign last_slot = (dl_beat.addr[3:1] == 3'b111);

	// ==================================================
	// Code register
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (cheat_wr_in)
			cheat_code[slot_lsb +: 16] <= dl_beat.data;
	end

	// ==================================================
	// Pulses
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= cheat_wr_in && last_slot; // Entry complete next cycle
			cheat_clear <= cheat_start; // Old table dropped before new entries
		end
	end

endmodule

//--- hw/bios_packer.sv
// BIOS packer that joins two download half-words into one addressed 32-bit write
`timescale 1ns/1ps
`include "loader_macros.svh"

module bios_packer (
	input logic clk_sys,
	input logic reset,
	input logic bios_wr_in,
	input loader_pkg::dl_beat_s dl_beat,
	output logic bios_wr_valid,
	output loader_pkg::bios_wr_s bios_wr
);

	loader_pkg::dl_data_t low_half; // Waits for its partner

	// Lower half-word of each word
	always_ff @(posedge clk_sys) begin
		if (bios_wr_in && !dl_beat.addr[1])
			low_half <= dl_beat.data;
	end

	// Upper half completes the word
	always_ff @(posedge clk_sys) begin
		if (bios_wr_in && dl_beat.addr[1]) begin
			bios_wr.data <= {dl_beat.data, low_half};
			bios_wr.addr <= dl_beat.addr[`LDR_BIOS_AW+1:2]; // Byte to word address
		end
	end

	// One-cycle strobe with the word
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr_valid <= 1'b0;
		else
			bios_wr_valid <= bios_wr_in && dl_beat.addr[1];
	end

endmodule

//--- hw/cart_scanner.sv
// Cartridge scanner that tracks load status, cart type, last address and the large-flash signature
`timescale 1ns/1ps

module cart_scanner (
	input logic clk_sys,
	input logic reset,
	input logic cart_start,
	input logic cart_end,
	input loader_pkg::cart_type_t cart_type,
	input logic cart_wr,
	input loader_pkg::dl_beat_s dl_beat,
	output loader_pkg::cart_info_s cart_info
);

	// Nine ASCII bytes, first byte in the top position
	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";

	logic [63:0] history; // Last eight image bytes, newest at the bottom
	loader_pkg::dl_addr_t last_wr_addr; // Address of the latest cart beat
	logic wr_q; // Cart strobe one cycle ago
	logic new_beat; // Beat shown for the first time, a stalled beat repeats
	logic [7:0] byte_lo; // First byte of the beat in image order
	logic [7:0] byte_hi;
	logic hit_lo; // Signature ends on the low byte
	logic hit_hi; // Signature ends on the high byte

	assign byte_lo = dl_beat.data[7:0];
	assign byte_hi = dl_beat.data[15:8];

	// Held beat keeps its address, so a repeat is the same address twice in a row
	assign new_beat = cart_wr && !(wr_q && dl_beat.addr == last_wr_addr);

	// Both alignments, the signature may start on an odd byte
	assign hit_lo = ({history, byte_lo} == FLASH_SIG);
	assign hit_hi = ({history[55:0], byte_lo, byte_hi} == FLASH_SIG);

	// ==================================================
	// Byte history
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset || cart_end)
			history <= '0; // No bytes from an earlier image
		else if (new_beat)
			history <= {history[47:0], byte_lo, byte_hi};
	end

	always_ff @(posedge clk_sys) begin
		if (cart_wr)
			last_wr_addr <= dl_beat.addr;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			wr_q <= 1'b0;
		else
			wr_q <= cart_wr;
	end

	// ==================================================
	// Status record
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_info <= '0;
		end else begin
			if (cart_start) begin
				cart_info.loaded <= 1'b1;
				cart_info.cart_type <= cart_type; // Captured by the router on entry
				cart_info.large_flash <= 1'b0;
			end
			// A match in the first beat still counts
			if (new_beat && (hit_lo || hit_hi))
				cart_info.large_flash <= 1'b1;
			if (cart_end)
				cart_info.last_addr <= last_wr_addr; // Final beat, written a cycle or more ago
		end
	end

endmodule

//--- hw/download_router.sv
// Download router that classifies the active download and steers write strobes to one consumer
`timescale 1ns/1ps
`include "loader_macros.svh"

module download_router (
	input logic clk_sys,
	input logic reset,
	input logic dl_active,
	input logic [`LDR_IDX_W-1:0] dl_index,
	input logic dl_wr,
	output logic cart_start,
	output logic cart_end,
	output logic cheat_start,
	output loader_pkg::cart_type_t cart_type,
	output logic cart_wr,
	output logic bios_wr_in,
	output logic cheat_wr_in
);

	loader_pkg::dl_kind_e kind_next;
	loader_pkg::dl_kind_e kind; // Kind seen by the consumers
	loader_pkg::dl_kind_e kind_q; // One cycle older, for edges

	// Decode index into a download kind
	always_comb begin
		if (!dl_active)
			kind_next = loader_pkg::KIND_NONE;
		else if (dl_index == `LDR_IDX_W'(`LDR_IDX_BIOS))
			kind_next = loader_pkg::KIND_BIOS;
		else if (dl_index == `LDR_IDX_W'(`LDR_IDX_CHEAT))
			kind_next = loader_pkg::KIND_CHEAT;
		else
			kind_next = loader_pkg::KIND_CART; // Everything in between
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind <= loader_pkg::KIND_NONE;
			kind_q <= loader_pkg::KIND_NONE;
		end else begin
			kind <= kind_next;
			kind_q <= kind;
		end
	end

	// Type is stable for the whole download, grab it on entry
	always_ff @(posedge clk_sys) begin
		if (kind_next == loader_pkg::KIND_CART && kind != loader_pkg::KIND_CART)
			cart_type <= dl_index[7:6];
	end

	// ==================================================
	// Edges and strobes
	// ==================================================
	assign cart_start = (kind == loader_pkg::KIND_CART) && (kind_q != loader_pkg::KIND_CART);
	assign cart_end = (kind_q == loader_pkg::KIND_CART) && (kind != loader_pkg::KIND_CART);
	assign cheat_start = (kind == loader_pkg::KIND_CHEAT) && (kind_q != loader_pkg::KIND_CHEAT);

	assign cart_wr = dl_wr && (kind == loader_pkg::KIND_CART); // Same cycle as the host strobe
	assign bios_wr_in = dl_wr && (kind == loader_pkg::KIND_BIOS);
	assign cheat_wr_in = dl_wr && (kind == loader_pkg::KIND_CHEAT);

endmodule

//--- hw/loader_pkg.sv
// Shared types of the download loader: vector widths, download kinds and bundled buses
`include "loader_macros.svh"

package loader_pkg;

	// ==================================================
	// Plain vectors
	// ==================================================
	typedef logic [`LDR_ADDR_W-1:0] dl_addr_t; // Byte address on the download port
	typedef logic [`LDR_DATA_W-1:0] dl_data_t; // One beat of data
	typedef logic [`LDR_ADDR_W-2:0] mem_addr_t; // Half-word address into external memory
	typedef logic [`LDR_BIOS_AW-1:0] bios_addr_t; // BIOS word address
	typedef logic [2*`LDR_DATA_W-1:0] bios_word_t; // Two half-words joined
	typedef logic [`LDR_CHEAT_W-1:0] cheat_code_t; // Full cheat entry
	typedef logic [1:0] cart_type_t; // Index bits 7..6

	// Active download, one destination each
	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_BIOS,
		KIND_CART,
		KIND_CHEAT
	} dl_kind_e;

	// ==================================================
	// Bundles
	// ==================================================
	typedef struct packed {
		dl_addr_t addr; // Byte address, always even
		dl_data_t data; // Low byte first in image order
	} dl_beat_s;

	typedef struct packed {
		bios_addr_t addr;
		bios_word_t data; // Upper half from odd half-word
	} bios_wr_s;

	typedef struct packed {
		logic loaded; // A cart has been downloaded since reset
		cart_type_t cart_type;
		logic large_flash; // Signature found somewhere in the image
		dl_addr_t last_addr; // Address of the final beat
	} cart_info_s;

	typedef struct packed {
		mem_addr_t addr;
		dl_data_t data;
	} mem_wr_s;

endpackage

//--- hw/loader_macros.svh
// Download loader constants for widths, download indexes, ROM placement and memory credits
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ==================================================
// Download port
// ==================================================
`define LDR_ADDR_W 27 // Byte address of a download beat
`define LDR_DATA_W 16 // One half-word per beat
`define LDR_IDX_W 8 // Download index from the host

// Index values with a fixed meaning
`define LDR_IDX_BIOS 0 // System ROM image
`define LDR_IDX_CHEAT 255 // Cheat table, all ones
// Every other index is a cartridge, type in bits 7..6

// ==================================================
// Memory side
// ==================================================
`define LDR_ROM_BASE 786432 // Byte base of cart ROM, past flash and WRAM
`define LDR_ROM_CREDITS 4 // Writes the memory can hold in flight

// ==================================================
// Consumers
// ==================================================
`define LDR_CHEAT_W 128 // Flags, address, compare, replace
`define LDR_BIOS_AW 12 // 4K words of BIOS

`endif
